// File: testbench/dm_golden.txt
# name burst op addr wdata halted unavail resumeack exp_data exp_haltreq exp_resumereq exp_ndmreset
# op: 1 read, 2 write; all values in hex; burst lines go out back to back
rd_ctrl_reset      0 1 10 00000000 0 0 0 00000000 0 0 0
rd_stat_reset      0 1 11 00000000 0 0 0 000c0c82 0 0 0
wr_inactive        0 2 10 80020002 0 0 0 00000000 0 0 0
rd_ctrl_inactive   0 1 10 00000000 0 0 0 00000000 0 0 0
wr_activate        0 2 10 00000001 0 0 0 00000000 0 0 0
wr_halt_h2         0 2 10 80020001 0 0 0 00000000 4 0 0
rd_ctrl_halt       0 1 10 00000000 0 0 0 80020001 4 0 0
rd_stat_halted     0 1 11 00000000 5 0 0 000c0382 4 0 0
rd_stat_unavail    0 1 11 00000000 5 4 0 000c3082 4 0 0
rd_haltsum         0 1 40 00000000 5 4 0 00000005 4 0 0
wr_sel_h1          0 2 10 00010001 5 0 0 00000000 0 0 0
rd_stat_run_h1     0 1 11 00000000 5 0 0 000c0c82 0 0 0
rd_unknown         0 1 12 00000000 0 0 0 00000000 0 0 0
wr_resume_h2       0 2 10 40020001 0 0 0 00000000 0 4 0
rd_ctrl_resume     0 1 10 00000000 0 0 0 40020001 0 4 0
rd_stat_rack       0 1 11 00000000 0 0 4 000f0c82 0 0 0
rd_ctrl_after_rack 0 1 10 00000000 0 0 0 00020001 0 0 0
wr_ack_h2          0 2 10 10020001 0 0 0 00000000 0 0 0
rd_stat_ack_h2     0 1 11 00000000 0 0 0 00000c82 0 0 0
wr_sel_h0          0 2 10 00000001 0 0 0 00000000 0 0 0
rd_stat_h0         0 1 11 00000000 0 0 0 000c0c82 0 0 0
wr_ndmreset        0 2 10 00020003 0 0 0 00000000 0 0 1
rd_stat_ndm        0 1 11 00000000 0 0 0 000c0c82 0 0 1
wr_ack_after_ndm   0 2 10 10020001 0 0 0 00000000 0 0 0
rd_stat_ack2       0 1 11 00000000 0 0 0 00000c82 0 0 0
wr_sel_h7          0 2 10 00070001 0 0 0 00000000 0 0 0
rd_stat_h7         0 1 11 00000000 0 0 0 0000c082 0 0 0
rd_b_ctrl          1 1 10 00000000 0 0 0 00070001 0 0 0
wr_b_sel0          1 2 10 00000001 0 0 0 00000000 0 0 0
rd_b_ctrl2         1 1 10 00000000 0 0 0 00000001 0 0 0
rd_b_sum           1 1 40 00000000 a 0 0 0000000a 0 0 0
rd_b_stat          1 1 11 00000000 a 0 0 000c0c82 0 0 0

// File: src.f
rtl/dm_dmi_pkg.sv
rtl/dm_regs_pkg.sv
rtl/dm_resp_fifo.sv
rtl/dm_ctrl_regs.sv
rtl/dm_hart_slice.sv
rtl/dm_status_collect.sv
rtl/dm_top.sv
testbench/tb_clk_gen.sv
testbench/tb_dm_top.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module tb_dm_top -Mdir obj_dir -o sim_dm
./obj_dir/sim_dm | tee sim.log

if grep -q "Verification failed" sim.log || ! grep -q "Verification passed" sim.log; then
  echo "simulation reported failure, see sim.log"
  exit 1
fi
echo "simulation finished without errors"

// File: testbench/tb_dm_top.sv
// Testbench for the debug module front end with four harts.
// Transactions and expected values come from testbench/dm_golden.txt.
// Lines marked as burst are sent back to back while responses stall.
// Response ready is dropped at random outside of bursts.
`timescale 1ns/10ps
`default_nettype none

module tb_dm_top;
  import dm_dmi_pkg::*;

  localparam int unsigned NrHarts = 4;
  localparam int unsigned CyclesPerLine = 40;
  localparam int unsigned StallCycles = 6;

  typedef struct packed {
    logic               burst;
    dtm_op_e            op;
    logic [6:0]         addr;
    logic [31:0]        wdata;
    logic [NrHarts-1:0] halted;
    logic [NrHarts-1:0] unavail;
    logic [NrHarts-1:0] rack;
    logic [31:0]        exp_data;
    logic [NrHarts-1:0] exp_haltreq;
    logic [NrHarts-1:0] exp_resumereq;
    logic               exp_ndmreset;
  } vec_t;

  logic               clk;
  logic               rst_n;
  logic               dmi_req_valid;
  dmi_req_t           dmi_req;
  logic               dmi_req_ready;
  logic               dmi_resp_valid;
  logic               dmi_resp_ready;
  dmi_resp_t          dmi_resp;
  logic               ndmreset;
  logic               dmactive;
  logic [NrHarts-1:0] halted;
  logic [NrHarts-1:0] unavailable;
  logic [NrHarts-1:0] resumeack;
  logic [NrHarts-1:0] haltreq;
  logic [NrHarts-1:0] resumereq;
  logic [NrHarts-1:0] clear_resumeack;

  vec_t        vecs[$];
  string       names[$];
  int unsigned errors = 0;
  int unsigned timeouts = 0;
  int unsigned cycles = 0;
  int unsigned limit = 0;
  logic        stall = 1'b0;

  // expected dmactive and resume pulse, kept from the dmcontrol rules
  logic               exp_dmactive = 1'b0;
  logic [NrHarts-1:0] exp_clear = '0;
  logic [9:0]         model_sel;
  string              cur_name = "none";
  string              pulse_name = "none";

  tb_clk_gen i_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  dm_top #(
    .NrHarts (NrHarts)
  ) dm_top_i (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .dmi_req_valid_i   (dmi_req_valid),
    .dmi_req_i         (dmi_req),
    .dmi_req_ready_o   (dmi_req_ready),
    .dmi_resp_valid_o  (dmi_resp_valid),
    .dmi_resp_ready_i  (dmi_resp_ready),
    .dmi_resp_o        (dmi_resp),
    .ndmreset_o        (ndmreset),
    .dmactive_o        (dmactive),
    .halted_i          (halted),
    .unavailable_i     (unavailable),
    .resumeack_i       (resumeack),
    .haltreq_o         (haltreq),
    .resumereq_o       (resumereq),
    .clear_resumeack_o (clear_resumeack)
  );

  // ----------------------------------------
  // checks and reporting
  // ----------------------------------------
  task automatic check_val(input string name, input string what,
                           input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("FAIL %s %s: expected 0x%08h, actual 0x%08h", name, what, exp, act);
    end
  endtask

  task automatic check_harts(input string name, input vec_t v);
    check_val(name, "haltreq", 32'(v.exp_haltreq), 32'(haltreq));
    check_val(name, "resumereq", 32'(v.exp_resumereq), 32'(resumereq));
    check_val(name, "ndmreset", 32'(v.exp_ndmreset), 32'(ndmreset));
    check_val(name, "dmactive", 32'(exp_dmactive), 32'(dmactive));
  endtask

  task automatic report_counts();
    $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
  endtask

  // ----------------------------------------
  // golden file
  // ----------------------------------------
  task automatic read_golden();
    int          fd;
    int          code;
    string       line;
    string       name;
    vec_t        v;
    logic [31:0] t_burst;
    logic [31:0] t_op;
    logic [31:0] t_addr;
    logic [31:0] t_wdata;
    logic [31:0] t_halt;
    logic [31:0] t_unav;
    logic [31:0] t_rack;
    logic [31:0] t_data;
    logic [31:0] t_hreq;
    logic [31:0] t_rreq;
    logic [31:0] t_ndm;
    fd = $fopen("testbench/dm_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open testbench/dm_golden.txt");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code > 0 && line.len() > 1 && line.getc(0) != 8'h23) begin
        code = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h", name, t_burst, t_op,
                       t_addr, t_wdata, t_halt, t_unav, t_rack, t_data, t_hreq, t_rreq, t_ndm);
        if (code == 12) begin
          v.burst         = t_burst[0];
          v.op            = dtm_op_e'(t_op[1:0]);
          v.addr          = t_addr[6:0];
          v.wdata         = t_wdata;
          v.halted        = t_halt[NrHarts-1:0];
          v.unavail       = t_unav[NrHarts-1:0];
          v.rack          = t_rack[NrHarts-1:0];
          v.exp_data      = t_data;
          v.exp_haltreq   = t_hreq[NrHarts-1:0];
          v.exp_resumereq = t_rreq[NrHarts-1:0];
          v.exp_ndmreset  = t_ndm[0];
          vecs.push_back(v);
          names.push_back(name);
        end else begin
          $display("malformed line in golden file: %s", line);
          errors++;
        end
      end
    end
    $fclose(fd);
  endtask

  // ----------------------------------------
  // DMI host side
  // ----------------------------------------
  // starts at a rising edge, returns at the accepting edge
  task automatic send_req(input string name, input vec_t v);
    logic accepted;
    #1;
    cur_name      = name;
    halted        = v.halted;
    unavailable   = v.unavail;
    resumeack     = v.rack;
    dmi_req.addr  = v.addr;
    dmi_req.op    = v.op;
    dmi_req.data  = v.wdata;
    dmi_req_valid = 1'b1;
    accepted      = 1'b0;
    while (!accepted) begin
      @(posedge clk);
      accepted = dmi_req_ready;
    end
  endtask

  task automatic get_resp(output logic [31:0] data, output logic [1:0] resp);
    logic got;
    got = 1'b0;
    while (!got) begin
      @(posedge clk);
      if (dmi_resp_valid && dmi_resp_ready) begin
        got  = 1'b1;
        data = dmi_resp.data;
        resp = dmi_resp.resp;
      end
    end
  endtask

  task automatic run_single(input int idx);
    logic [31:0] data;
    logic [1:0]  resp;
    @(posedge clk);
    send_req(names[idx], vecs[idx]);
    #1;
    dmi_req_valid = 1'b0;
    get_resp(data, resp);
    check_val(names[idx], "data", vecs[idx].exp_data, data);
    check_val(names[idx], "resp", 32'(DTM_SUCCESS), 32'(resp));
    #1;
    check_harts(names[idx], vecs[idx]);
  endtask

  // requests go out back to back while the response side is held off
  task automatic run_burst(input int first, input int last);
    int          ks;
    int          kr;
    logic [31:0] data;
    logic [1:0]  resp;
    @(posedge clk);
    stall = 1'b1;
    fork
      begin
        for (ks = first; ks <= last; ks++) begin
          send_req(names[ks], vecs[ks]);
        end
        #1;
        dmi_req_valid = 1'b0;
      end
      begin
        repeat (StallCycles) @(posedge clk);
        stall = 1'b0;
        for (kr = first; kr <= last; kr++) begin
          get_resp(data, resp);
          check_val(names[kr], "data", vecs[kr].exp_data, data);
          check_val(names[kr], "resp", 32'(DTM_SUCCESS), 32'(resp));
        end
      end
    join
    #1;
    check_harts(names[last], vecs[last]);
  endtask

  always begin
    @(posedge clk);
    #1;
    dmi_resp_ready = stall ? 1'b0 : ($urandom_range(3) != 0);
  end

  // ----------------------------------------
  // dmcontrol model for dmactive and the resume pulse
  // ----------------------------------------
  // a resumereq write while active pulses the hart that the write selects
  always @(posedge clk) begin
    check_val(pulse_name, "clear_resumeack", 32'(exp_clear), 32'(clear_resumeack));
    exp_clear = '0;
    if (dmi_req_valid && dmi_req_ready && dmi_req.op == DTM_WRITE &&
        dmi_req.addr == 7'h10) begin
      model_sel = (exp_dmactive && dmi_req.data[0]) ? dmi_req.data[25:16] : 10'd0;
      if (exp_dmactive && dmi_req.data[30] && model_sel < NrHarts) begin
        exp_clear = NrHarts'(1) << model_sel;
      end
      exp_dmactive = dmi_req.data[0];
      pulse_name   = cur_name;
    end
  end

  // watchdog
  always @(posedge clk) begin
    cycles++;
    if (limit != 0 && cycles >= limit) begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      timeouts++;
      report_counts();
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    int i;
    int j;
    void'($urandom(99));
    dmi_req_valid  = 1'b0;
    dmi_req        = '0;
    dmi_resp_ready = 1'b0;
    halted         = '0;
    unavailable    = '0;
    resumeack      = '0;
    read_golden();
    limit = CyclesPerLine * vecs.size() + 100;
    wait (rst_n);
    i = 0;
    while (i < vecs.size()) begin
      if (vecs[i].burst) begin
        j = i;
        while (j + 1 < vecs.size() && vecs[j+1].burst) j++;
        run_burst(i, j);
        i = j + 1;
      end else begin
        run_single(i);
        i++;
      end
    end
    if (vecs.size() == 0) begin
      $display("no transactions were read from the golden file");
      errors++;
    end
    report_counts();
    if (errors == 0 && timeouts == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/tb_clk_gen.sv
// Clock and reset source for the testbench.
// 4 ns period; reset is released 1 ns after the last reset edge.
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
  parameter int unsigned ResetCycles = 4
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// File: rtl/dm_top.sv
// Register front end of a RISC-V debug module on the DMI handshake.
// Every accepted request returns exactly one response word, in order;
// writes answer with zero data. Up to two responses are held while
// the host stalls. NrHarts ranges from 1 to 32.
`timescale 1ns/10ps
`default_nettype none

module dm_top #(
  parameter int unsigned NrHarts = 1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 dmi_req_valid_i,
  input  dm_dmi_pkg::dmi_req_t dmi_req_i,
  output logic                 dmi_req_ready_o,
  output logic                 dmi_resp_valid_o,
  input  logic                 dmi_resp_ready_i,
  output dm_dmi_pkg::dmi_resp_t dmi_resp_o,
  output logic                 ndmreset_o,
  output logic                 dmactive_o,
  input  logic [NrHarts-1:0]   halted_i,
  input  logic [NrHarts-1:0]   unavailable_i,
  input  logic [NrHarts-1:0]   resumeack_i,
  output logic [NrHarts-1:0]   haltreq_o,
  output logic [NrHarts-1:0]   resumereq_o,
  output logic [NrHarts-1:0]   clear_resumeack_o
);
  import dm_dmi_pkg::*;
  import dm_regs_pkg::*;

  logic                      resp_full;
  logic                      resp_empty;
  logic                      resp_push;
  logic                      resp_pop;
  logic [31:0]               rd_data;
  hart_ctrl_t                hart_ctrl;
  hart_status_t [NrHarts-1:0] hart_status;
  dmstatus_t                 dmstatus;
  logic [31:0]               haltsum0;
  logic                      sel_resume_pending;

  assign dmi_req_ready_o  = ~resp_full;
  assign dmi_resp_valid_o = ~resp_empty;
  assign resp_pop         = dmi_resp_ready_i & ~resp_empty;
  assign dmi_resp_o.resp  = DTM_SUCCESS;

  dm_resp_fifo i_resp_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (resp_push),
    .data_i  (rd_data),
    .pop_i   (resp_pop),
    .full_o  (resp_full),
    .empty_o (resp_empty),
    .data_o  (dmi_resp_o.data)
  );

  dm_ctrl_regs i_ctrl_regs (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .req_valid_i          (dmi_req_valid_i),
    .req_i                (dmi_req_i),
    .req_ready_i          (dmi_req_ready_o),
    .dmstatus_i           (dmstatus),
    .haltsum0_i           (haltsum0),
    .sel_resume_pending_i (sel_resume_pending),
    .push_o               (resp_push),
    .rd_data_o            (rd_data),
    .hart_ctrl_o          (hart_ctrl),
    .ndmreset_o           (ndmreset_o),
    .dmactive_o           (dmactive_o)
  );

  // ----------------------------------------
  // one slice per hart
  // ----------------------------------------
  for (genvar h = 0; h < NrHarts; h++) begin : g_hart
    dm_hart_slice #(
      .HartIndex (h)
    ) i_hart_slice (
      .clk_i             (clk_i),
      .rst_ni            (rst_ni),
      .hart_ctrl_i       (hart_ctrl),
      .halted_i          (halted_i[h]),
      .unavailable_i     (unavailable_i[h]),
      .resumeack_i       (resumeack_i[h]),
      .status_o          (hart_status[h]),
      .haltreq_o         (haltreq_o[h]),
      .resumereq_o       (resumereq_o[h]),
      .clear_resumeack_o (clear_resumeack_o[h])
    );
  end

  dm_status_collect #(
    .NrHarts (NrHarts)
  ) i_status_collect (
    .hart_status_i        (hart_status),
    .hartsel_i            (hart_ctrl.hartsel),
    .dmstatus_o           (dmstatus),
    .haltsum0_o           (haltsum0),
    .sel_resume_pending_o (sel_resume_pending)
  );

endmodule

`default_nettype wire

// File: rtl/dm_status_collect.sv
// Builds dmstatus and haltsum0 from the per-hart status words.
// Purely combinational. NrHarts must not exceed 32, since haltsum0
// only covers harts 0 to 31. A hartsel past the last hart reports
// nonexistent and zero for every other per-hart flag.
`timescale 1ns/10ps
`default_nettype none

module dm_status_collect #(
  parameter int unsigned NrHarts = 1
) (
  input  dm_regs_pkg::hart_status_t [NrHarts-1:0]   hart_status_i,
  input  logic [dm_regs_pkg::HartSelWidth-1:0]      hartsel_i,
  output dm_regs_pkg::dmstatus_t                    dmstatus_o,
  output logic [31:0]                               haltsum0_o,
  output logic                                      sel_resume_pending_o
);
  import dm_regs_pkg::*;

  hart_status_t sel;
  logic         exists;

  // select by compare so out-of-range hartsel needs no index guard
  always_comb begin
    sel    = '0;
    exists = 1'b0;
    for (int unsigned k = 0; k < NrHarts; k++) begin
      if (hartsel_i == HartSelWidth'(k)) begin
        sel    = hart_status_i[k];
        exists = 1'b1;
      end
    end
  end

  always_comb begin
    dmstatus_o                = '0;
    dmstatus_o.version        = DbgVersion013;
    dmstatus_o.authenticated  = 1'b1;
    dmstatus_o.allnonexistent = ~exists;
    dmstatus_o.anynonexistent = ~exists;
    // halted and running exclude unavailable
    dmstatus_o.allhalted      = sel.halted & ~sel.unavail;
    dmstatus_o.anyhalted      = sel.halted & ~sel.unavail;
    dmstatus_o.allrunning     = exists & ~sel.halted & ~sel.unavail;
    dmstatus_o.anyrunning     = exists & ~sel.halted & ~sel.unavail;
    dmstatus_o.allunavail     = sel.unavail;
    dmstatus_o.anyunavail     = sel.unavail;
    dmstatus_o.allresumeack   = sel.resumeack;
    dmstatus_o.anyresumeack   = sel.resumeack;
    dmstatus_o.allhavereset   = sel.havereset;
    dmstatus_o.anyhavereset   = sel.havereset;
  end

  always_comb begin
    haltsum0_o = '0;
    for (int unsigned k = 0; k < NrHarts; k++) begin
      haltsum0_o[k] = hart_status_i[k].halted;
    end
  end

  assign sel_resume_pending_o = sel.resume_pending;

endmodule

`default_nettype wire

// File: rtl/dm_hart_slice.sv
// Per-hart state of the debug module: havereset and resume pending.
// Control arrives as a broadcast; the slice acts only when hartsel
// matches HartIndex. The hart is expected to drop resumeack when
// clear_resumeack_o pulses.
`timescale 1ns/10ps
`default_nettype none

module dm_hart_slice #(
  parameter int unsigned HartIndex = 0
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  dm_regs_pkg::hart_ctrl_t   hart_ctrl_i,
  input  logic                      halted_i,
  input  logic                      unavailable_i,
  input  logic                      resumeack_i,
  output dm_regs_pkg::hart_status_t status_o,
  output logic                      haltreq_o,
  output logic                      resumereq_o,
  output logic                      clear_resumeack_o
);
  import dm_regs_pkg::*;

  logic selected;
  logic havereset_q;
  logic resume_pending_q;
  logic resume_start;

  assign selected     = (hart_ctrl_i.hartsel == HartSelWidth'(HartIndex));
  assign resume_start = hart_ctrl_i.resume_start & selected;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      havereset_q      <= 1'b1;
      resume_pending_q <= 1'b0;
    end else begin
      // ndmreset wins over the acknowledge
      if (hart_ctrl_i.ndmreset) begin
        havereset_q <= 1'b1;
      end else if (hart_ctrl_i.ack_havereset && selected) begin
        havereset_q <= 1'b0;
      end
      if (!hart_ctrl_i.dmactive) begin
        resume_pending_q <= 1'b0;
      end else if (resume_start) begin
        resume_pending_q <= 1'b1;
      end else if (resumeack_i) begin
        resume_pending_q <= 1'b0;
      end
    end
  end

  assign haltreq_o         = hart_ctrl_i.haltreq & selected;
  assign resumereq_o       = resume_pending_q;
  assign clear_resumeack_o = resume_start;

  always_comb begin
    status_o.halted         = halted_i;
    status_o.unavail        = unavailable_i;
    status_o.resumeack      = resumeack_i;
    status_o.havereset      = havereset_q;
    status_o.resume_pending = resume_pending_q;
  end

  // a halt request also needs an active debug module
  a_haltreq_selected: assert property (@(posedge clk_i) disable iff (!rst_ni)
    haltreq_o |-> (selected && hart_ctrl_i.dmactive))
    else $error("haltreq raised on an unselected hart");

endmodule

`default_nettype wire

// File: rtl/dm_ctrl_regs.sv
// DMI request decode, dmcontrol storage and read data mux.
// Decode is combinational on the request word; a write updates
// dmcontrol at the accepting edge. While dmactive is low only
// dmactive can be written. resumereq and ackhavereset are not
// stored, they become one-cycle pulses to the hart slices.
// Unknown addresses read as zero and ignore writes.
`timescale 1ns/10ps
`default_nettype none

module dm_ctrl_regs (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    req_valid_i,
  input  dm_dmi_pkg::dmi_req_t    req_i,
  input  logic                    req_ready_i,
  input  dm_regs_pkg::dmstatus_t  dmstatus_i,
  input  logic [31:0]             haltsum0_i,
  input  logic                    sel_resume_pending_i,
  output logic                    push_o,
  output logic [31:0]             rd_data_o,
  output dm_regs_pkg::hart_ctrl_t hart_ctrl_o,
  output logic                    ndmreset_o,
  output logic                    dmactive_o
);
  import dm_dmi_pkg::*;
  import dm_regs_pkg::*;

  dmcontrol_t dmcontrol_d;
  dmcontrol_t dmcontrol_q;
  dmcontrol_t wdata;
  dmcontrol_t ctrl_rdata;
  logic       accept;
  logic       ctrl_wr;
  logic       resume_start_q;
  logic       ack_havereset_q;

  assign accept  = req_valid_i & req_ready_i;
  assign push_o  = accept;
  assign ctrl_wr = accept && (req_i.op == DTM_WRITE) && (req_i.addr == DMControl);
  assign wdata   = dmcontrol_t'(req_i.data);

  // ----------------------------------------
  // dmcontrol update
  // ----------------------------------------
  always_comb begin
    dmcontrol_d = dmcontrol_q;
    if (ctrl_wr) begin
      if (dmcontrol_q.dmactive) begin
        dmcontrol_d.haltreq   = wdata.haltreq;
        dmcontrol_d.hartsello = wdata.hartsello;
        dmcontrol_d.ndmreset  = wdata.ndmreset;
      end
      dmcontrol_d.dmactive = wdata.dmactive;
    end
    // soft reset holds everything else at zero
    if (!dmcontrol_d.dmactive) begin
      dmcontrol_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dmcontrol_q     <= '0;
      resume_start_q  <= 1'b0;
      ack_havereset_q <= 1'b0;
    end else begin
      dmcontrol_q     <= dmcontrol_d;
      resume_start_q  <= ctrl_wr & dmcontrol_q.dmactive & wdata.resumereq;
      ack_havereset_q <= ctrl_wr & dmcontrol_q.dmactive & wdata.ackhavereset;
    end
  end

  // ----------------------------------------
  // read data
  // ----------------------------------------
  always_comb begin
    ctrl_rdata = dmcontrol_q;
    // pulse covers the cycle before the slice sets its pending flag
    ctrl_rdata.resumereq = sel_resume_pending_i | resume_start_q;
    rd_data_o = '0;
    if (req_i.op == DTM_READ) begin
      case (req_i.addr)
        DMControl: rd_data_o = ctrl_rdata;
        DMStatus:  rd_data_o = dmstatus_i;
        HaltSum0:  rd_data_o = haltsum0_i;
        default:   rd_data_o = '0;
      endcase
    end
  end

  always_comb begin
    hart_ctrl_o.hartsel       = dmcontrol_q.hartsello;
    hart_ctrl_o.haltreq       = dmcontrol_q.haltreq;
    hart_ctrl_o.resume_start  = resume_start_q;
    hart_ctrl_o.ack_havereset = ack_havereset_q;
    hart_ctrl_o.ndmreset      = dmcontrol_q.ndmreset;
    hart_ctrl_o.dmactive      = dmcontrol_q.dmactive;
  end

  assign ndmreset_o = dmcontrol_q.ndmreset;
  assign dmactive_o = dmcontrol_q.dmactive;

  a_pulse_after_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (resume_start_q || ack_havereset_q) |-> $past(ctrl_wr))
    else $error("hart pulse without a dmcontrol write");

endmodule

`default_nettype wire

// File: rtl/dm_resp_fifo.sv
// Two-entry response queue for DMI read data.
// Pushes while full are dropped and pops while empty are ignored;
// the front end never issues either, which the assertions check.
// Storage has no reset, only the pointers do.
`timescale 1ns/10ps
`default_nettype none

module dm_resp_fifo (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        push_i,
  input  logic [31:0] data_i,
  input  logic        pop_i,
  output logic        full_o,
  output logic        empty_o,
  output logic [31:0] data_o
);

  // pointers carry one wrap bit above the entry index
  logic [1:0]  wr_ptr_q;
  logic [1:0]  rd_ptr_q;
  logic [31:0] mem_q [2];
  logic        push_en;
  logic        pop_en;

  assign empty_o = (wr_ptr_q == rd_ptr_q);
  assign full_o  = (wr_ptr_q[0] == rd_ptr_q[0]) && (wr_ptr_q[1] != rd_ptr_q[1]);
  assign data_o  = mem_q[rd_ptr_q[0]];

  assign push_en = push_i & ~full_o;
  assign pop_en  = pop_i & ~empty_o;

  always_ff @(posedge clk_i) begin
    if (push_en) begin
      mem_q[wr_ptr_q[0]] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= 2'b00;
      rd_ptr_q <= 2'b00;
    end else begin
      if (push_en) wr_ptr_q <= wr_ptr_q + 2'd1;
      if (pop_en) rd_ptr_q <= rd_ptr_q + 2'd1;
    end
  end

  // ready/valid at the top must keep both sides legal
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(push_i && full_o)) else $error("response queue pushed while full");

  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(pop_i && empty_o)) else $error("response queue popped while empty");

endmodule

`default_nettype wire

// File: rtl/dm_regs_pkg.sv
// Register map and hart-slice types of the debug module front end.
// Only dmcontrol, dmstatus and haltsum0 are mapped; hart selection
// uses hartsello alone, so at most 1024 harts are addressable.
`default_nettype none

package dm_regs_pkg;

  localparam logic [3:0] DbgVersion013 = 4'd2;
  localparam int unsigned HartSelWidth = 10;

  typedef enum logic [6:0] {
    DMControl = 7'h10,
    DMStatus  = 7'h11,
    HaltSum0  = 7'h40
  } dm_csr_e;

  // ----------------------------------------
  // register layouts
  // ----------------------------------------
  typedef struct packed {
    logic                    haltreq;
    logic                    resumereq;
    logic                    zero2;
    logic                    ackhavereset;
    logic [1:0]              zero1;
    logic [HartSelWidth-1:0] hartsello;
    logic [13:0]             zero0;
    logic                    ndmreset;
    logic                    dmactive;
  } dmcontrol_t;

  typedef struct packed {
    logic [11:0] zero1;
    logic        allhavereset;
    logic        anyhavereset;
    logic        allresumeack;
    logic        anyresumeack;
    logic        allnonexistent;
    logic        anynonexistent;
    logic        allunavail;
    logic        anyunavail;
    logic        allrunning;
    logic        anyrunning;
    logic        allhalted;
    logic        anyhalted;
    logic        authenticated;
    logic [2:0]  zero0;
    logic [3:0]  version;
  } dmstatus_t;

  // ----------------------------------------
  // control broadcast and per-hart status
  // ----------------------------------------
  typedef struct packed {
    logic [HartSelWidth-1:0] hartsel;
    logic                    haltreq;
    logic                    resume_start;
    logic                    ack_havereset;
    logic                    ndmreset;
    logic                    dmactive;
  } hart_ctrl_t;

  typedef struct packed {
    logic halted;
    logic unavail;
    logic resumeack;
    logic havereset;
    logic resume_pending;
  } hart_status_t;

endpackage

`default_nettype wire

// File: rtl/dm_dmi_pkg.sv
// DMI transport types shared by the debug module front end.
// The design only ever answers with DTM_SUCCESS; the other codes
// exist so that the response field decodes fully on the host side.
`default_nettype none

package dm_dmi_pkg;

  // ----------------------------------------
  // opcodes and response codes
  // ----------------------------------------
  typedef enum logic [1:0] {
    DTM_NOP   = 2'h0,
    DTM_READ  = 2'h1,
    DTM_WRITE = 2'h2
  } dtm_op_e;

  typedef enum logic [1:0] {
    DTM_SUCCESS = 2'h0,
    DTM_ERR     = 2'h2,
    DTM_BUSY    = 2'h3
  } dtm_resp_e;

  // ----------------------------------------
  // request and response words
  // ----------------------------------------
  typedef struct packed {
    logic [6:0]  addr;
    dtm_op_e     op;
    logic [31:0] data;
  } dmi_req_t;

  typedef struct packed {
    logic [31:0] data;
    dtm_resp_e   resp;
  } dmi_resp_t;

endpackage

`default_nettype wire
